//--- hdl/corePkg.sv
package corePkg;

    ////////////////////
    // Widths and sizes
    ////////////////////
    localparam int XLen       = 32;
    localparam int NumThreads = 4;
    localparam int RegAddrW   = 4;      // 16 regs per thread, top rs/rd bit dropped

    typedef logic [NumThreads-1:0] threadT; // One-hot, bit n is thread n

    // Reset PC per thread, thread n boots at n*0x100
    localparam logic [NumThreads-1:0][XLen-1:0] BootPc = {
        32'h0000_0300, 32'h0000_0200, 32'h0000_0100, 32'h0000_0000
    };

    ////////////////////
    // RV32I opcodes
    ////////////////////
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuiPc  = 7'b0010111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpOp     = 7'b0110011;

    localparam logic [XLen-1:0] NopInstr = 32'h0000_0013; // addi x0,x0,0

    // ALU ops, coded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        AluAdd  = 4'b0000,
        AluSub  = 4'b1000,
        AluSll  = 4'b0001,
        AluSlt  = 4'b0010,
        AluSltu = 4'b0011,
        AluXor  = 4'b0100,
        AluSrl  = 4'b0101,
        AluSra  = 4'b1101,
        AluOr   = 4'b0110,
        AluAnd  = 4'b0111
    } aluOpT;

    // Decoded control set, Q101H to Q102H
    typedef struct packed {
        logic jal;
        logic jalr;
        logic branch;
        logic iImm;     // I-type immediate as ALU operand 2
        logic regWr;
        logic lui;
        logic auipc;
        logic memToReg;
        logic memRd;
        logic memWr;
        logic pcToReg;  // Link value PC+4 to rd
    } ctrlT;

endpackage

//--- hdl/execBus.sv
`timescale 1ns/1ns

// Execute results, registered at Q102H to Q103H
interface execBus import corePkg::*; ();
    logic [XLen-1:0]     aluOut;    // Result or memory address
    logic [XLen-1:0]     pcPlus4;
    logic [XLen-1:0]     storeData; // rs2 of a store
    logic [RegAddrW-1:0] rdPtr;
    logic [2:0]          funct3;    // Access size
    logic                regWr;
    logic                memRd;
    logic                memWr;
    logic                memToReg;
    logic                pcToReg;
    threadT              thread;

    modport source (
        output aluOut, pcPlus4, storeData, rdPtr, funct3,
        output regWr, memRd, memWr, memToReg, pcToReg, thread
    );

    modport sink (
        input aluOut, pcPlus4, storeData, rdPtr, funct3,
        input regWr, memRd, memWr, memToReg, pcToReg, thread
    );

endinterface

//--- hdl/wbBus.sv
`timescale 1ns/1ns

// Q104H register write, combinational
interface wbBus import corePkg::*; ();
    logic                wrEn;
    logic [RegAddrW-1:0] wrPtr;
    logic [XLen-1:0]     wrData;
    threadT              wrThread;  // Bank select, one-hot

    modport source (output wrEn, wrPtr, wrData, wrThread);
    modport sink   (input  wrEn, wrPtr, wrData, wrThread);

endinterface

//--- hdl/threadFetch.sv
`timescale 1ns/1ns

module threadFetch import corePkg::*; (
    input  logic            QClk,
    input  logic            rst,
    input  logic [XLen-1:0] nextPc,     // From Q102H
    input  threadT          exThread,   // Thread at Q102H
    output logic [XLen-1:0] PcQ100H,
    output logic [XLen-1:0] pcQ101,
    output threadT          threadQ101
);

    threadT                               ring;   // Thread at Q100H
    logic [NumThreads-1:0][XLen-1:0]      pcReg;

    ////////////////////
    // Thread ring
    ////////////////////
    // One token, rotates left each cycle
    always_ff @(posedge QClk) begin
        if (rst) begin
            ring <= threadT'(1);                        // Thread 0 first
        end else begin
            ring <= {ring[NumThreads-2:0], ring[NumThreads-1]};
        end
    end

    ////////////////////
    // Per-thread PCs
    ////////////////////
    // Written at end of the owner's Q102H, read two cycles later
    always_ff @(posedge QClk) begin
        for (int t = 0; t < NumThreads; t++) begin
            if (rst) begin
                pcReg[t] <= BootPc[t];
            end else if (exThread[t]) begin
                pcReg[t] <= nextPc;
            end
        end
    end

    // One-hot mux of the issuing thread's PC
    always_comb begin
        PcQ100H = '0;
        for (int t = 0; t < NumThreads; t++) begin
            if (ring[t]) begin
                PcQ100H = PcQ100H | pcReg[t];
            end
        end
    end

    // Q100H to Q101H
    always_ff @(posedge QClk) begin
        pcQ101 <= PcQ100H;
    end

    always_ff @(posedge QClk) begin
        if (rst) begin
            threadQ101 <= '0;               // No thread in flight
        end else begin
            threadQ101 <= ring;
        end
    end

endmodule

//--- hdl/decodeRegs.sv
`timescale 1ns/1ns

module decodeRegs import corePkg::*; (
    input  logic            QClk,
    input  logic            rst,
    input  logic [XLen-1:0] instr,      // Fetched word at Q101H
    input  logic [XLen-1:0] pcQ101,
    input  threadT          threadQ101,
    wbBus.sink              wb,
    output logic [XLen-1:0] instrQ102,
    output logic [XLen-1:0] pcQ102,
    output threadT          threadQ102,
    output logic [XLen-1:0] rs1Data,
    output logic [XLen-1:0] rs2Data,
    output ctrlT            ctrl
);

    logic [6:0]          opcode;
    logic [RegAddrW-1:0] rs1Ptr;
    logic [RegAddrW-1:0] rs2Ptr;
    logic [XLen-1:0]     rs1Next;
    logic [XLen-1:0]     rs2Next;
    ctrlT                ctrlNext;

    // Four banks of 16 regs, one per thread
    logic [XLen-1:0] regBank [NumThreads][16];

    assign opcode = instr[6:0];
    assign rs1Ptr = instr[15 +: RegAddrW];  // Bit 19 ignored
    assign rs2Ptr = instr[20 +: RegAddrW];  // Bit 24 ignored

    ////////////////////
    // Opcode decode
    ////////////////////
    always_comb begin
        ctrlNext.jal      = (opcode == OpJal);
        ctrlNext.jalr     = (opcode == OpJalr);
        ctrlNext.branch   = (opcode == OpBranch);
        ctrlNext.iImm     = (opcode == OpImm) || (opcode == OpLoad) || (opcode == OpJalr);
        ctrlNext.regWr    = (opcode == OpLui) || (opcode == OpAuiPc) || (opcode == OpJal)
                         || (opcode == OpJalr) || (opcode == OpLoad) || (opcode == OpImm)
                         || (opcode == OpOp);
        ctrlNext.lui      = (opcode == OpLui);
        ctrlNext.auipc    = (opcode == OpAuiPc);
        ctrlNext.memToReg = (opcode == OpLoad);
        ctrlNext.memRd    = (opcode == OpLoad);
        ctrlNext.memWr    = (opcode == OpStore);
        ctrlNext.pcToReg  = (opcode == OpJal) || (opcode == OpJalr); // Link
    end

    ////////////////////
    // Register read
    ////////////////////
    // Bank picked by Q101H thread, zero if none
    always_comb begin
        rs1Next = '0;
        rs2Next = '0;
        for (int t = 0; t < NumThreads; t++) begin
            if (threadQ101[t]) begin
                rs1Next = regBank[t][rs1Ptr];
                rs2Next = regBank[t][rs2Ptr];
            end
        end
    end

    ////////////////////
    // Register write
    ////////////////////
    // Q104H write lands before the thread's next Q101H read
    always_ff @(posedge QClk) begin
        for (int t = 0; t < NumThreads; t++) begin
            regBank[t][0] <= '0;                            // x0 pinned
            if (wb.wrEn && wb.wrThread[t] && (wb.wrPtr != '0)) begin
                regBank[t][wb.wrPtr] <= wb.wrData;
            end
        end
    end

    // Q101H to Q102H payload
    always_ff @(posedge QClk) begin
        instrQ102 <= instr;
        pcQ102    <= pcQ101;
        rs1Data   <= rs1Next;
        rs2Data   <= rs2Next;
    end

    // Q101H to Q102H control
    always_ff @(posedge QClk) begin
        if (rst) begin
            ctrl       <= '0;   // No write, no strobe
            threadQ102 <= '0;   // Keeps PC enables quiet
        end else begin
            ctrl       <= ctrlNext;
            threadQ102 <= threadQ101;
        end
    end

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ns

module executeStage import corePkg::*; (
    input  logic            QClk,
    input  logic            rst,
    input  logic [XLen-1:0] instrQ102,
    input  logic [XLen-1:0] pcQ102,
    input  threadT          threadQ102,
    input  logic [XLen-1:0] rs1Data,
    input  logic [XLen-1:0] rs2Data,
    input  ctrlT            ctrl,
    output logic [XLen-1:0] nextPc,
    output threadT          exThread,
    execBus.source          ex
);

    logic [XLen-1:0] iImm;
    logic [XLen-1:0] sImm;
    logic [XLen-1:0] bImm;
    logic [XLen-1:0] uImm;
    logic [XLen-1:0] jImm;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7Bit5;
    aluOpT           aluOp;
    logic [XLen-1:0] aluIn1;
    logic [XLen-1:0] aluIn2;
    logic [4:0]      shamt;
    logic [XLen-1:0] aluOut;
    logic            branchTaken;
    logic [XLen-1:0] pcPlus4;

    ////////////////////
    // Field breakdown
    ////////////////////
    assign opcode     = instrQ102[6:0];
    assign funct3     = instrQ102[14:12];
    assign funct7Bit5 = instrQ102[30];      // SUB and SRA/SRAI

    // Immediates, all sign extended from bit 31
    assign iImm = {{20{instrQ102[31]}}, instrQ102[31:20]};
    assign sImm = {{20{instrQ102[31]}}, instrQ102[31:25], instrQ102[11:7]};
    assign bImm = {{20{instrQ102[31]}}, instrQ102[7], instrQ102[30:25],
                   instrQ102[11:8], 1'b0};
    assign uImm = {instrQ102[31:12], 12'b0};
    assign jImm = {{12{instrQ102[31]}}, instrQ102[19:12], instrQ102[20],
                   instrQ102[30:21], 1'b0};

    ////////////////////
    // ALU control
    ////////////////////
    // Anything but OP/OP-IMM adds (address, LUI, AUIPC, JALR)
    always_comb begin
        aluOp = AluAdd;
        if ((opcode == OpOp) || (opcode == OpImm)) begin
            unique case (funct3)
                3'b000:  aluOp = ((opcode == OpOp) && funct7Bit5) ? AluSub : AluAdd;
                3'b001:  aluOp = AluSll;
                3'b010:  aluOp = AluSlt;
                3'b011:  aluOp = AluSltu;
                3'b100:  aluOp = AluXor;
                3'b101:  aluOp = funct7Bit5 ? AluSra : AluSrl;
                3'b110:  aluOp = AluOr;
                default: aluOp = AluAnd;
            endcase
        end
    end

    // Operand select
    always_comb begin
        if (ctrl.lui) begin
            aluIn1 = '0;
        end else if (ctrl.auipc) begin
            aluIn1 = pcQ102;
        end else begin
            aluIn1 = rs1Data;
        end

        if (ctrl.lui || ctrl.auipc) begin
            aluIn2 = uImm;
        end else if (ctrl.iImm) begin
            aluIn2 = iImm;
        end else if (ctrl.memWr) begin
            aluIn2 = sImm;          // Store address offset
        end else begin
            aluIn2 = rs2Data;       // OP and branches
        end
    end

    assign shamt = aluIn2[4:0];

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        unique case (aluOp)
            AluAdd:  aluOut = aluIn1 + aluIn2;
            AluSub:  aluOut = aluIn1 - aluIn2;
            AluSlt:  aluOut = {31'b0, $signed(aluIn1) < $signed(aluIn2)};
            AluSltu: aluOut = {31'b0, aluIn1 < aluIn2};
            AluSll:  aluOut = aluIn1 << shamt;
            AluSrl:  aluOut = aluIn1 >> shamt;
            AluSra:  aluOut = $signed(aluIn1) >>> shamt;
            AluXor:  aluOut = aluIn1 ^ aluIn2;
            AluOr:   aluOut = aluIn1 | aluIn2;
            default: aluOut = aluIn1 & aluIn2;      // AluAnd
        endcase
    end

    // Branch compare straight on rs1/rs2
    always_comb begin
        branchTaken = 1'b0;
        if (ctrl.branch) begin
            case (funct3)
                3'b000:  branchTaken = (rs1Data == rs2Data);                    // BEQ
                3'b001:  branchTaken = (rs1Data != rs2Data);                    // BNE
                3'b100:  branchTaken = ($signed(rs1Data) <  $signed(rs2Data));  // BLT
                3'b101:  branchTaken = ($signed(rs1Data) >= $signed(rs2Data));  // BGE
                3'b110:  branchTaken = (rs1Data <  rs2Data);                    // BLTU
                3'b111:  branchTaken = (rs1Data >= rs2Data);                    // BGEU
                default: branchTaken = 1'b0;
            endcase
        end
    end

    ////////////////////
    // Next PC
    ////////////////////
    assign pcPlus4 = pcQ102 + 32'd4;

    always_comb begin
        if (ctrl.jalr) begin
            nextPc = {aluOut[XLen-1:1], 1'b0};  // rs1+imm, bit 0 cleared
        end else if (ctrl.jal) begin
            nextPc = pcQ102 + jImm;
        end else if (branchTaken) begin
            nextPc = pcQ102 + bImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign exThread = threadQ102;   // PC write enable, one-hot

    // Q102H to Q103H payload
    always_ff @(posedge QClk) begin
        ex.aluOut    <= aluOut;
        ex.pcPlus4   <= pcPlus4;
        ex.storeData <= rs2Data;
        ex.rdPtr     <= instrQ102[7 +: RegAddrW];   // Bit 11 ignored
        ex.funct3    <= funct3;
        ex.memToReg  <= ctrl.memToReg;
        ex.pcToReg   <= ctrl.pcToReg;
        ex.thread    <= threadQ102;
    end

    // Enables
    always_ff @(posedge QClk) begin
        if (rst) begin
            ex.regWr <= 1'b0;
            ex.memRd <= 1'b0;
            ex.memWr <= 1'b0;
        end else begin
            ex.regWr <= ctrl.regWr;
            ex.memRd <= ctrl.memRd;
            ex.memWr <= ctrl.memWr;
        end
    end

endmodule

//--- hdl/memWriteback.sv
`timescale 1ns/1ns

module memWriteback import corePkg::*; (
    input  logic            QClk,
    input  logic            rst,
    execBus.sink            ex,
    input  logic [XLen-1:0] MemRdDataQ104H,
    output logic [XLen-1:0] MemAdrsQ103H,
    output logic [XLen-1:0] MemWrDataWQ103H,
    output logic            CtrlMemWrQ103H,
    output logic            CtrlMemRdQ103H,
    output logic [3:0]      MemByteEnQ103H,
    wbBus.source            wb
);

    logic [XLen-1:0]     aluOutQ104;
    logic [XLen-1:0]     pcPlus4Q104;
    logic [RegAddrW-1:0] rdPtrQ104;
    logic                memToRegQ104;
    logic                pcToRegQ104;
    logic                regWrQ104;
    threadT              threadQ104;

    ////////////////////
    // Q103H data memory
    ////////////////////
    assign MemAdrsQ103H    = ex.aluOut;
    assign MemWrDataWQ103H = ex.storeData;  // Unshifted, lane 0 up
    assign CtrlMemWrQ103H  = ex.memWr;
    assign CtrlMemRdQ103H  = ex.memRd;

    always_comb begin
        case (ex.funct3[1:0])
            2'b00:   MemByteEnQ103H = 4'b0001;  // Byte
            2'b01:   MemByteEnQ103H = 4'b0011;  // Half
            2'b10:   MemByteEnQ103H = 4'b1111;  // Word
            default: MemByteEnQ103H = 4'b0000;  // Illegal size, no lanes
        endcase
    end

    // Q103H to Q104H
    always_ff @(posedge QClk) begin
        aluOutQ104   <= ex.aluOut;
        pcPlus4Q104  <= ex.pcPlus4;
        rdPtrQ104    <= ex.rdPtr;
        memToRegQ104 <= ex.memToReg;
        pcToRegQ104  <= ex.pcToReg;
        threadQ104   <= ex.thread;
        regWrQ104    <= rst ? 1'b0 : ex.regWr;
    end

    ////////////////////
    // Q104H writeback
    ////////////////////
    assign wb.wrEn     = regWrQ104;
    assign wb.wrPtr    = rdPtrQ104;
    assign wb.wrThread = threadQ104;
    assign wb.wrData   = memToRegQ104 ? MemRdDataQ104H :   // Load
                         pcToRegQ104  ? pcPlus4Q104    :   // Link
                                        aluOutQ104;

endmodule

//--- hdl/core4t.sv
`timescale 1ns/1ns

module core4t import corePkg::*; (
    input  logic            QClk,
    input  logic            rst,
    // Instruction memory
    output logic [XLen-1:0] PcQ100H,
    input  logic [XLen-1:0] InstFetchQ101H,     // Word for last cycle's PC
    // Data memory
    output logic [XLen-1:0] MemAdrsQ103H,
    output logic [XLen-1:0] MemWrDataWQ103H,
    output logic            CtrlMemWrQ103H,
    output logic            CtrlMemRdQ103H,
    output logic [3:0]      MemByteEnQ103H,
    input  logic [XLen-1:0] MemRdDataQ104H      // One cycle after strobe
);

    logic [XLen-1:0] pcQ101;
    threadT          threadQ101;
    logic [XLen-1:0] instrQ102;
    logic [XLen-1:0] pcQ102;
    threadT          threadQ102;
    logic [XLen-1:0] rs1Data;
    logic [XLen-1:0] rs2Data;
    ctrlT            ctrl;
    logic [XLen-1:0] nextPc;
    threadT          exThread;

    execBus exBus ();   // Q103H
    wbBus   wbIf ();    // Q104H

    ////////////////////
    // Pipe
    ////////////////////
    threadFetch fetch (
        .QClk, .rst, .nextPc, .exThread, .PcQ100H, .pcQ101, .threadQ101
    );

    decodeRegs decode (
        .QClk, .rst, .instr(InstFetchQ101H), .pcQ101, .threadQ101,
        .wb(wbIf), .instrQ102, .pcQ102, .threadQ102, .rs1Data, .rs2Data, .ctrl
    );

    executeStage execute (
        .QClk, .rst, .instrQ102, .pcQ102, .threadQ102, .rs1Data, .rs2Data,
        .ctrl, .nextPc, .exThread, .ex(exBus)
    );

    memWriteback memWb (
        .QClk, .rst, .ex(exBus), .MemRdDataQ104H, .MemAdrsQ103H,
        .MemWrDataWQ103H, .CtrlMemWrQ103H, .CtrlMemRdQ103H,
        .MemByteEnQ103H, .wb(wbIf)
    );

endmodule

//--- tb/core4tTable.svh
// Expected stores, in order per thread: thread, address, data, byte enable
localparam int NumExp = 33;

localparam storeT ExpStores [NumExp] = '{
    // Thread 0, ALU results of 100 and -7
    '{2'd0, 32'h400, 32'h0000_005D, 4'hF}, '{2'd0, 32'h404, 32'h0000_006B, 4'hF},
    '{2'd0, 32'h408, 32'h0000_0001, 4'hF}, '{2'd0, 32'h40C, 32'h0000_0000, 4'hF},
    '{2'd0, 32'h410, 32'h0000_0320, 4'hF}, '{2'd0, 32'h414, 32'hFFFF_FFFC, 4'hF},
    '{2'd0, 32'h418, 32'h0000_000F, 4'hF}, '{2'd0, 32'h41C, 32'hFFFF_FF9D, 4'hF},
    '{2'd0, 32'h420, 32'hFFFF_FFFD, 4'hF}, '{2'd0, 32'h424, 32'h0000_0060, 4'hF},
    // Thread 1, one marker per branch test, then the links
    '{2'd1, 32'h500, 32'h5A, 4'hF}, '{2'd1, 32'h504, 32'h5A, 4'hF},
    '{2'd1, 32'h508, 32'h5A, 4'hF}, '{2'd1, 32'h50C, 32'h5A, 4'hF},
    '{2'd1, 32'h510, 32'h5A, 4'hF}, '{2'd1, 32'h514, 32'h5A, 4'hF},
    '{2'd1, 32'h518, 32'h5A, 4'hF}, '{2'd1, 32'h51C, 32'h5A, 4'hF},
    '{2'd1, 32'h520, 32'h5A, 4'hF}, '{2'd1, 32'h524, 32'h5A, 4'hF},
    '{2'd1, 32'h528, 32'h5A, 4'hF}, '{2'd1, 32'h52C, 32'h5A, 4'hF},
    '{2'd1, 32'h530, 32'h190, 4'hF}, '{2'd1, 32'h534, 32'h1A0, 4'hF},
    // Thread 2, word, reload, byte, half, AUIPC
    '{2'd2, 32'h600, 32'h1234_5678, 4'hF}, '{2'd2, 32'h604, 32'h1234_5678, 4'hF},
    '{2'd2, 32'h608, 32'h0000_0078, 4'h1}, '{2'd2, 32'h60C, 32'h0000_5678, 4'h3},
    '{2'd2, 32'h610, 32'h0000_121C, 4'hF},
    // Thread 3, x0 then its own x1..x3
    '{2'd3, 32'h700, 32'h0000_0000, 4'hF}, '{2'd3, 32'h704, 32'hFFFF_FFFF, 4'hF},
    '{2'd3, 32'h708, 32'h0000_0333, 4'hF}, '{2'd3, 32'h70C, 32'h0000_0332, 4'hF}
};

task automatic loadPrograms();
    logic [31:0] prog [$];
    prog = '{addi(1, 0, 100), addi(2, 0, -7), rType(7'h00, 3'b000, 3, 1, 2), sw(3, 'h400),
             rType(7'h20, 3'b000, 4, 1, 2), sw(4, 'h404), rType(7'h00, 3'b010, 5, 2, 1),
             sw(5, 'h408), rType(7'h00, 3'b011, 6, 2, 1), sw(6, 'h40C),
             iType(3'b001, 7, 1, 3, OpImm), sw(7, 'h410), iType(3'b101, 8, 2, 'h401, OpImm),
             sw(8, 'h414), iType(3'b101, 9, 2, 28, OpImm), sw(9, 'h418),
             rType(7'h00, 3'b100, 10, 1, 2), sw(10, 'h41C), rType(7'h00, 3'b110, 11, 1, 2),
             sw(11, 'h420), rType(7'h00, 3'b111, 12, 1, 2), sw(12, 'h424), jType(0, 0)};
    loadThread(0, prog);
    // x1=5 x2=-3 x3=5, x15 stored only on a wrong path
    prog = '{addi(1, 0, 5), addi(2, 0, -3), addi(3, 0, 5), addi(13, 0, 'h5A),
             addi(15, 0, 'h7BD),
             bType(3'b000, 1, 3, 8), sw(15, 'h5FC), sw(13, 'h500),
             bType(3'b000, 1, 2, 8), sw(13, 'h504),
             bType(3'b001, 1, 2, 8), sw(15, 'h5FC), sw(13, 'h508),
             bType(3'b001, 1, 3, 8), sw(13, 'h50C),
             bType(3'b100, 2, 1, 8), sw(15, 'h5FC), sw(13, 'h510),
             bType(3'b100, 1, 2, 8), sw(13, 'h514),
             bType(3'b101, 1, 2, 8), sw(15, 'h5FC), sw(13, 'h518),
             bType(3'b101, 2, 1, 8), sw(13, 'h51C),
             bType(3'b110, 1, 2, 8), sw(15, 'h5FC), sw(13, 'h520),
             bType(3'b110, 2, 1, 8), sw(13, 'h524),
             bType(3'b111, 2, 1, 8), sw(15, 'h5FC), sw(13, 'h528),
             bType(3'b111, 1, 2, 8), sw(13, 'h52C),
             jType(4, 8), sw(15, 'h5FC), sw(4, 'h530),
             addi(5, 0, 'h1A4), iType(3'b000, 6, 5, 0, OpJalr), sw(15, 'h5FC), sw(6, 'h534),
             jType(0, 0)};
    loadThread(1, prog);
    prog = '{uType(OpLui, 1, 'h12345), addi(1, 1, 'h678), sw(1, 'h600),
             iType(3'b010, 2, 0, 'h600, OpLoad), sw(2, 'h604), sType(3'b000, 1, 0, 'h608),
             sType(3'b001, 1, 0, 'h60C), uType(OpAuiPc, 4, 1), sw(4, 'h610), jType(0, 0)};
    loadThread(2, prog);
    prog = '{addi(0, 0, 55), sw(0, 'h700), addi(1, 0, -1), addi(2, 0, 'h333),
             rType(7'h00, 3'b000, 3, 1, 2), sw(1, 'h704), sw(2, 'h708), sw(3, 'h70C),
             jType(0, 0)};
    loadThread(3, prog);
endtask

//--- tb/core4tTb.sv
`timescale 1ns/1ns

module core4tTb import corePkg::*; ();

    localparam int StoreTimeout = 400;  // Cycles per store wait
    localparam int QuietCycles  = 40;   // Idle time for stray stores

    typedef struct packed {
        logic [1:0]  thr;
        logic [31:0] adr;
        logic [31:0] data;
        logic [3:0]  be;
    } storeT;

    logic        QClk;
    logic        rst;
    logic [31:0] PcQ100H;
    logic [31:0] InstFetchQ101H;
    logic [31:0] MemAdrsQ103H;
    logic [31:0] MemWrDataWQ103H;
    logic        CtrlMemWrQ103H;
    logic        CtrlMemRdQ103H;
    logic [3:0]  MemByteEnQ103H;
    logic [31:0] MemRdDataQ104H;

    logic [31:0] imem [256];        // 64 words per thread
    logic [31:0] dmem [512];
    logic [31:0] fetchAdr;
    logic        fetchRst;
    logic        memRead;
    logic [8:0]  memIdx;
    storeT       seenQ [NumThreads][$];  // Observed stores per thread
    logic        storeSeen;
    int          errCount;
    int          checkCount;

    core4t UUT (
        .QClk, .rst, .PcQ100H, .InstFetchQ101H, .MemAdrsQ103H, .MemWrDataWQ103H,
        .CtrlMemWrQ103H, .CtrlMemRdQ103H, .MemByteEnQ103H, .MemRdDataQ104H
    );

    ////////////////////
    // Instruction encoders
    ////////////////////
    function automatic logic [31:0] rType(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                          int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OpOp};
    endfunction

    function automatic logic [31:0] iType(logic [2:0] f3, int rd, int rs1, int imm,
                                          logic [6:0] op);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] sType(logic [2:0] f3, int rs2, int rs1, int imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OpStore};
    endfunction

    function automatic logic [31:0] bType(logic [2:0] f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OpBranch};
    endfunction

    function automatic logic [31:0] uType(logic [6:0] op, int rd, int imm20);
        return {imm20[19:0], 5'(rd), op};
    endfunction

    function automatic logic [31:0] jType(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OpJal};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return iType(3'b000, rd, rs1, imm, OpImm);
    endfunction

    function automatic logic [31:0] sw(int rs2, int imm);  // Base is x0
        return sType(3'b010, rs2, 0, imm);
    endfunction

    // Bytes a store is allowed to change
    function automatic logic [31:0] laneMask(logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic loadThread(int thr, logic [31:0] words [$]);
        for (int i = 0; i < words.size(); i++) begin
            imem[thr*64 + i] = words[i];
        end
    endtask

    `include "core4tTable.svh"

    task automatic checkEqual(string name, logic [31:0] got, logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // Clock and memories
    ////////////////////
    initial begin
        QClk = 1'b0;
        forever #4 QClk = ~QClk;
    end

    // Registered fetch with NOP in reset
    always @(posedge QClk) begin
        fetchAdr = PcQ100H;
        fetchRst = rst;
        #1 InstFetchQ101H = fetchRst ? NopInstr : imem[fetchAdr[9:2]];
    end

    always @(posedge QClk) begin
        memRead = CtrlMemRdQ103H;
        memIdx  = MemAdrsQ103H[10:2];
        if (CtrlMemWrQ103H) begin
            for (int k = 0; k < 4; k++) begin
                if (MemByteEnQ103H[k]) begin
                    dmem[memIdx][8*k +: 8] = MemWrDataWQ103H[8*k +: 8];
                end
            end
        end
        #1 if (memRead) MemRdDataQ104H = dmem[memIdx];     // Read data in Q104H
    end

    ////////////////////
    // Store monitor
    ////////////////////
    // Sampled mid-cycle with the thread taken from address bits 9:8
    always @(negedge QClk) begin
        if ($time > 0) begin                // Skip the X to 0 edge at start
            if (rst && ((CtrlMemWrQ103H !== 1'b0) || (CtrlMemRdQ103H !== 1'b0))) begin
                errCount++;
                $display("Memory strobe not low during reset at t=%0t", $time);
            end
            if ((CtrlMemRdQ103H !== 1'b0) && !storeSeen) begin
                errCount++;
                $display("Load strobe asserted before the first store at t=%0t", $time);
            end
        end
        if (!rst && CtrlMemWrQ103H) begin
            storeSeen = 1'b1;
            seenQ[MemAdrsQ103H[9:8]].push_back(
                {MemAdrsQ103H[9:8], MemAdrsQ103H, MemWrDataWQ103H, MemByteEnQ103H});
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        storeT got;
        storeT exp;
        logic  timedOut;
        int    waitCnt;
        rst            = 1'b1;
        InstFetchQ101H = NopInstr;
        MemRdDataQ104H = '0;
        storeSeen      = 1'b0;
        errCount       = 0;
        checkCount     = 0;
        timedOut       = 1'b0;
        for (int i = 0; i < 512; i++) begin
            dmem[i] = 32'hA5C3_0000 ^ (i * 32'h0001_0007);  // Address-dependent fill
        end
        loadPrograms();

        repeat (8) @(posedge QClk);
        #1 rst = 1'b0;

        // Issue order after reset with thread n at n*0x100
        checkEqual("PcQ100H", PcQ100H, 32'h0);
        for (int t = 1; t < NumThreads; t++) begin
            @(posedge QClk);
            #1 checkEqual("PcQ100H", PcQ100H, 32'(t * 'h100));
        end

        for (int e = 0; e < NumExp && !timedOut; e++) begin
            exp     = ExpStores[e];
            waitCnt = 0;
            while (seenQ[exp.thr].size() == 0 && waitCnt < StoreTimeout) begin
                @(posedge QClk);
                waitCnt++;
            end
            if (seenQ[exp.thr].size() == 0) begin
                errCount++;
                timedOut = 1'b1;
                $display("Timeout waiting for store %0d of thread %0d", e, exp.thr);
            end else begin
                got = seenQ[exp.thr].pop_front();
                checkEqual("MemAdrsQ103H", got.adr, exp.adr);
                checkEqual("MemWrDataWQ103H", got.data & laneMask(exp.be),
                           exp.data & laneMask(exp.be));
                checkEqual("MemByteEnQ103H", 32'(got.be), 32'(exp.be));
            end
        end

        // Threads sit in self-jumps so nothing more is expected
        if (!timedOut) begin
            repeat (QuietCycles) @(posedge QClk);
            for (int t = 0; t < NumThreads; t++) begin
                if (seenQ[t].size() != 0) begin
                    errCount++;
                    $display("Thread %0d made %0d unexpected stores", t, seenQ[t].size());
                end
            end
        end

        $display("Checks: %0d  Errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+tb
hdl/corePkg.sv
hdl/execBus.sv
hdl/wbBus.sv
hdl/threadFetch.sv
hdl/decodeRegs.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/core4t.sv
tb/core4tTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core4tTb
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f compile.f
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)
